// File: logic/core_pkg.sv
// Core package with data widths, instruction layout, opcodes and stage records
package core_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_NUM    = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W      = 15;
	localparam int OPCODE_W   = 6;

	// Instruction word bit positions
	localparam int INST_OPCODE_HI = 31;
	localparam int INST_OPCODE_LO = 26;
	localparam int INST_DEST_HI   = 25;
	localparam int INST_DEST_LO   = 21;
	localparam int INST_SRC0_HI   = 20;
	localparam int INST_SRC0_LO   = 16;
	localparam int INST_IMM_SEL   = 15;
	localparam int INST_SRC1_HI   = 14;
	localparam int INST_SRC1_LO   = 10;

	typedef enum logic [OPCODE_W-1:0] {
		op_nop = 6'd0,
		op_add = 6'd1,
		op_sub = 6'd2,
		op_and = 6'd3,
		op_or  = 6'd4,
		op_xor = 6'd5,
		op_shl = 6'd6,
		op_shr = 6'd7,
		op_sar = 6'd8,
		op_mov = 6'd9
	} opcode_e;

	typedef struct packed {
		logic [DATA_W-1:0] pc;
		logic [DATA_W-1:0] inst;
	} fetch_t;

	typedef struct packed {
		logic [DATA_W-1:0]     pc;
		opcode_e               opcode;
		logic [REG_ADDR_W-1:0] destination;
		logic [REG_ADDR_W-1:0] source0;
		logic [REG_ADDR_W-1:0] source1;
		logic                  source1_imm;
		logic [IMM_W-1:0]      imm;
		logic                  writeback;
	} decoded_t;

	typedef struct packed {
		logic [DATA_W-1:0]     pc;
		opcode_e               opcode;
		logic [REG_ADDR_W-1:0] destination;
		logic                  writeback;
		logic [DATA_W-1:0]     operand0;
		logic [DATA_W-1:0]     operand1;
	} issue_t;

	// Also used as the register file write record
	typedef struct packed {
		logic [DATA_W-1:0]     pc;
		logic [REG_ADDR_W-1:0] destination;
		logic                  writeback;
		logic [DATA_W-1:0]     data;
	} result_t;

endpackage

// File: logic/decoder.sv
// Decode stage that splits instruction words into registered decoded records
`timescale 1ns/1ps

module decoder (
	input  logic               clock,
	input  logic               arst_n,
	input  logic               prev_valid,
	input  core_pkg::fetch_t   prev,
	output logic               prev_lock,
	output logic               next_valid,
	output core_pkg::decoded_t next,
	input  logic               next_lock
);

	logic [core_pkg::OPCODE_W-1:0] raw_opcode;
	core_pkg::opcode_e             opcode;
	logic                          writeback;
	core_pkg::decoded_t            decoded;

	assign raw_opcode = prev.inst[core_pkg::INST_OPCODE_HI:core_pkg::INST_OPCODE_LO];

	// Unknown codes fall back to nop
	always_comb begin
		case (raw_opcode)
			core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
			core_pkg::op_or, core_pkg::op_xor, core_pkg::op_shl,
			core_pkg::op_shr, core_pkg::op_sar, core_pkg::op_mov: begin
				opcode = core_pkg::opcode_e'(raw_opcode);
			end
			default: begin
				opcode = core_pkg::op_nop;
			end
		endcase
	end

	assign writeback = (opcode != core_pkg::op_nop);

	always_comb begin
		decoded.pc          = prev.pc;
		decoded.opcode      = opcode;
		decoded.writeback   = writeback;
		// Nop carries no destination
		decoded.destination = writeback ?
			prev.inst[core_pkg::INST_DEST_HI:core_pkg::INST_DEST_LO] : '0;
		decoded.source0     = prev.inst[core_pkg::INST_SRC0_HI:core_pkg::INST_SRC0_LO];
		decoded.source1     = prev.inst[core_pkg::INST_SRC1_HI:core_pkg::INST_SRC1_LO];
		decoded.source1_imm = prev.inst[core_pkg::INST_IMM_SEL];
		decoded.imm         = prev.inst[core_pkg::IMM_W-1:0];
	end

	// Busy only while holding an item that downstream refuses
	assign prev_lock = next_valid && next_lock;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			next_valid <= 1'b0;
		end else if (!prev_lock) begin
			next_valid <= prev_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (prev_valid && !prev_lock) begin
			next <= decoded;
		end
	end

endmodule

// File: logic/dispatch.sv
// Dispatch stage with register file, pending-write scoreboard and operand read
`timescale 1ns/1ps

module dispatch (
	input  logic               clock,
	input  logic               arst_n,
	input  logic               prev_valid,
	input  core_pkg::decoded_t prev,
	output logic               prev_lock,
	output logic               next_valid,
	output core_pkg::issue_t   next,
	input  logic               next_lock,
	input  logic               reg_write_en,
	input  core_pkg::result_t  reg_write
);

	logic [core_pkg::DATA_W-1:0]  regs [core_pkg::REG_NUM];
	logic [core_pkg::REG_NUM-1:0] pending;
	logic                         src0_used;
	logic                         src1_used;
	logic                         hazard;
	logic                         out_busy;
	logic                         accept;
	core_pkg::issue_t             issue;

	// Which register reads the instruction actually depends on
	assign src0_used = (prev.opcode != core_pkg::op_nop) && (prev.opcode != core_pkg::op_mov);
	assign src1_used = (prev.opcode != core_pkg::op_nop) && !prev.source1_imm;

	// Read after write on either source, plus a pending destination so that
	// an older commit cannot clear the pending bit of a younger write
	assign hazard = (src0_used && pending[prev.source0]) ||
		(src1_used && pending[prev.source1]) ||
		(prev.writeback && pending[prev.destination]);

	assign out_busy  = next_valid && next_lock;
	assign prev_lock = out_busy || (prev_valid && hazard);
	assign accept    = prev_valid && !prev_lock;

	always_comb begin
		issue.pc          = prev.pc;
		issue.opcode      = prev.opcode;
		issue.destination = prev.destination;
		issue.writeback   = prev.writeback;
		issue.operand0    = regs[prev.source0];
		if (prev.source1_imm) begin
			issue.operand1 = {{(core_pkg::DATA_W - core_pkg::IMM_W){1'b0}}, prev.imm};
		end else begin
			issue.operand1 = regs[prev.source1];
		end
	end

	// Register file written in commit order by writeback
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < core_pkg::REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write_en) begin
			regs[reg_write.destination] <= reg_write.data;
		end
	end

	// Scoreboard
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pending <= '0;
		end else begin
			if (reg_write_en) begin
				pending[reg_write.destination] <= 1'b0;
			end
			if (accept && prev.writeback) begin
				pending[prev.destination] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			next_valid <= 1'b0;
		end else if (!out_busy) begin
			next_valid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			next <= issue;
		end
	end

endmodule

// File: logic/execute.sv
// Execute stage computing add, logic and shift results into a result record
`timescale 1ns/1ps

module execute (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              prev_valid,
	input  core_pkg::issue_t  prev,
	output logic              prev_lock,
	output logic              next_valid,
	output core_pkg::result_t next,
	input  logic              next_lock
);

	logic [4:0]                  shamt;
	logic [core_pkg::DATA_W-1:0] data;
	core_pkg::result_t           result;

	assign shamt = prev.operand1[4:0];

	always_comb begin
		case (prev.opcode)
			core_pkg::op_add: data = prev.operand0 + prev.operand1;
			core_pkg::op_sub: data = prev.operand0 - prev.operand1;
			core_pkg::op_and: data = prev.operand0 & prev.operand1;
			core_pkg::op_or:  data = prev.operand0 | prev.operand1;
			core_pkg::op_xor: data = prev.operand0 ^ prev.operand1;
			core_pkg::op_shl: data = prev.operand0 << shamt;
			core_pkg::op_shr: data = prev.operand0 >> shamt;
			core_pkg::op_sar: data = $unsigned($signed(prev.operand0) >>> shamt);
			core_pkg::op_mov: data = prev.operand1;
			default:          data = '0;
		endcase
	end

	always_comb begin
		result.pc          = prev.pc;
		result.destination = prev.destination;
		result.writeback   = prev.writeback;
		result.data        = data;
	end

	assign prev_lock = next_valid && next_lock;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			next_valid <= 1'b0;
		end else if (!prev_lock) begin
			next_valid <= prev_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (prev_valid && !prev_lock) begin
			next <= result;
		end
	end

endmodule

// File: logic/writeback.sv
// Writeback stage holding results for the consumer and committing them to the register file
`timescale 1ns/1ps

module writeback (
	input  logic              clock,
	input  logic              arst_n,
	input  logic              prev_valid,
	input  core_pkg::result_t prev,
	output logic              prev_lock,
	output logic              result_valid,
	output core_pkg::result_t result,
	input  logic              result_lock,
	output logic              reg_write_en,
	output core_pkg::result_t reg_write
);

	logic result_take;

	// Result leaves the port on this edge
	assign result_take = result_valid && !result_lock;

	assign prev_lock = result_valid && result_lock;

	// Commit together with the result transfer, so registers follow program order
	assign reg_write_en = result_take && result.writeback;
	assign reg_write    = result;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
		end else if (!prev_lock) begin
			result_valid <= prev_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (prev_valid && !prev_lock) begin
			result <= prev;
		end
	end

endmodule

// File: logic/core_pipeline.sv
// Four-stage integer pipeline top level linking decode, dispatch, execute and writeback
`timescale 1ns/1ps

module core_pipeline (
	input  logic               clock,
	input  logic               arst_n,
	input  logic               inst_valid,
	input  core_pkg::fetch_t   inst,
	output logic               inst_lock,
	output logic               result_valid,
	output core_pkg::result_t  result,
	input  logic               result_lock
);

	// Decode to dispatch
	logic               decoder2dispatch_valid;
	core_pkg::decoded_t decoder2dispatch;
	logic               dispatch2decoder_lock;

	// Dispatch to execute
	logic               dispatch2execute_valid;
	core_pkg::issue_t   dispatch2execute;
	logic               execute2dispatch_lock;

	// Execute to writeback
	logic               execute2writeback_valid;
	core_pkg::result_t  execute2writeback;
	logic               writeback2execute_lock;

	// Register file commit
	logic               reg_write_en;
	core_pkg::result_t  reg_write;

	decoder decoder_i (
		.clock      (clock),
		.arst_n     (arst_n),
		.prev_valid (inst_valid),
		.prev       (inst),
		.prev_lock  (inst_lock),
		.next_valid (decoder2dispatch_valid),
		.next       (decoder2dispatch),
		.next_lock  (dispatch2decoder_lock)
	);

	dispatch dispatch_i (
		.clock        (clock),
		.arst_n       (arst_n),
		.prev_valid   (decoder2dispatch_valid),
		.prev         (decoder2dispatch),
		.prev_lock    (dispatch2decoder_lock),
		.next_valid   (dispatch2execute_valid),
		.next         (dispatch2execute),
		.next_lock    (execute2dispatch_lock),
		.reg_write_en (reg_write_en),
		.reg_write    (reg_write)
	);

	execute execute_i (
		.clock      (clock),
		.arst_n     (arst_n),
		.prev_valid (dispatch2execute_valid),
		.prev       (dispatch2execute),
		.prev_lock  (execute2dispatch_lock),
		.next_valid (execute2writeback_valid),
		.next       (execute2writeback),
		.next_lock  (writeback2execute_lock)
	);

	writeback writeback_i (
		.clock        (clock),
		.arst_n       (arst_n),
		.prev_valid   (execute2writeback_valid),
		.prev         (execute2writeback),
		.prev_lock    (writeback2execute_lock),
		.result_valid (result_valid),
		.result       (result),
		.result_lock  (result_lock),
		.reg_write_en (reg_write_en),
		.reg_write    (reg_write)
	);

endmodule

// File: testbench/tb_core_pipeline.sv
// Testbench for the four-stage pipeline, driven and checked from a stimulus file
`timescale 1ns/1ps

module tb_core_pipeline;

	localparam int NUM_ENTRIES    = 20;
	localparam int IDX_W          = 5;
	localparam int TIMEOUT_CYCLES = 20 * NUM_ENTRIES + 100;

	logic              clock;
	logic              arst_n;
	logic              inst_valid;
	core_pkg::fetch_t  inst;
	logic              inst_lock;
	logic              result_valid;
	core_pkg::result_t result;
	logic              result_lock;

	// Entry holds inst [75:44], dest [43:36], writeback [35:32] and data [31:0]
	logic [75:0] stim_mem [NUM_ENTRIES];
	int          errors;
	int          recv;
	int          cycles;

	core_pipeline dut_i (
		.clock        (clock),
		.arst_n       (arst_n),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_lock    (inst_lock),
		.result_valid (result_valid),
		.result       (result),
		.result_lock  (result_lock)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Random back-pressure once half of the results are in
	initial begin
		result_lock = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			if (recv >= NUM_ENTRIES / 2) begin
				result_lock = ($urandom % 3 == 0);
			end else begin
				result_lock = 1'b0;
			end
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clock);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) begin
				$display("Timeout after %0d cycles, only %0d results arrived", cycles, recv);
				$display("TESTBENCH FAILED");
				$finish;
			end
		end
	end

	task automatic present_entry(input int index);
		inst_valid = 1'b1;
		inst.pc    = index * 4;
		inst.inst  = stim_mem[index[IDX_W-1:0]][75:44];
	endtask

	// Next instruction goes out once the current one is taken
	task automatic drive_instructions();
		int sent;
		sent = 0;
		present_entry(0);
		while (sent < NUM_ENTRIES) begin
			@(posedge clock);
			if (inst_valid && !inst_lock) begin
				sent++;
			end
			#1;
			if (sent < NUM_ENTRIES) begin
				present_entry(sent);
			end else begin
				inst_valid = 1'b0;
			end
		end
	endtask

	task automatic check_result(input int index);
		logic [75:0] entry;
		logic [4:0]  exp_dest;
		logic        exp_wb;
		logic [31:0] exp_data;
		entry    = stim_mem[index[IDX_W-1:0]];
		exp_dest = entry[40:36];
		exp_wb   = entry[32];
		exp_data = entry[31:0];
		if (result.pc != index * 4) begin
			errors++;
			$display("[ERROR] %0t: result %0d pc %h, expected %h", $time, index,
				result.pc, index * 4);
		end
		if (result.destination != exp_dest) begin
			errors++;
			$display("[ERROR] %0t: result %0d destination %0d, expected %0d", $time, index,
				result.destination, exp_dest);
		end
		if (result.writeback != exp_wb) begin
			errors++;
			$display("[ERROR] %0t: result %0d writeback %b, expected %b", $time, index,
				result.writeback, exp_wb);
		end
		if (result.data != exp_data) begin
			errors++;
			$display("[ERROR] %0t: result %0d data %h, expected %h", $time, index,
				result.data, exp_data);
		end
	endtask

	task automatic collect_results();
		while (recv < NUM_ENTRIES) begin
			@(posedge clock);
			if (result_valid && !result_lock) begin
				check_result(recv);
				recv++;
			end
		end
	endtask

	// Nothing may leave the result port after the last entry
	task automatic watch_for_extra(input int num_cycles);
		repeat (num_cycles) begin
			@(posedge clock);
			if (result_valid && !result_lock) begin
				errors++;
				$display("[ERROR] %0t: extra result with pc %h", $time, result.pc);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h4da8_78bc));
		arst_n     = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		errors     = 0;
		recv       = 0;
		$readmemh("testbench/stimulus.mem", stim_mem);
		repeat (10) @(posedge clock);
		#1;
		arst_n = 1'b1;
		if (inst_lock || result_valid) begin
			errors++;
			$display("[ERROR] %0t: inst_lock %b result_valid %b after reset, expected 0",
				$time, inst_lock, result_valid);
		end
		fork
			drive_instructions();
			collect_results();
		join
		watch_for_extra(20);
		$display("Results received: %0d of %0d, errors: %0d", recv, NUM_ENTRIES, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
logic/core_pkg.sv
logic/decoder.sv
logic/dispatch.sv
logic/execute.sv
logic/writeback.sv
logic/core_pipeline.sv
testbench/tb_core_pipeline.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
	--top-module tb_core_pipeline -Mdir obj_dir -o sim_core_pipeline || exit 1
output="$(./obj_dir/sim_core_pipeline)"
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

// File: testbench/stimulus.mem
// Columns: instruction word _ expected destination _ writeback flag _ expected data
// One entry per line, the PC of an entry is its line index times 4
04258000_01_1_00000000 // add r1, r5, #0
24409234_02_1_00001234 // mov r2, #0x1234
2460ffff_03_1_00007fff // mov r3, #0x7fff
04820c00_04_1_00009233 // add r4, r2, r3
08a20c00_05_1_ffff9235 // sub r5, r2, r3
0cc58ff0_06_1_00000230 // and r6, r5, #0x0ff0
10e6c001_07_1_00004231 // or r7, r6, #0x4001
15070800_08_1_00005005 // xor r8, r7, r2
19288011_09_1_a00a0000 // shl r9, r8, #17
21498008_0a_1_ffa00a00 // sar r10, r9, #8
1d690800_0b_1_00000a00 // shr r11, r9, r2
00640000_00_0_00000000 // nop with dest field r3
fc438055_00_0_00000000 // unknown opcode with dest field r2
25800800_0c_1_00001234 // mov r12, r2
05a38000_0d_1_00007fff // add r13, r3, #0
21c53000_0e_1_ffffffff // sar r14, r5, r12
09e08001_0f_1_ffffffff // sub r15, r0, #1
060f8002_10_1_00000001 // add r16, r15, #2
14303c00_01_1_fffffffe // xor r1, r16, r15
06410400_12_1_fffffffc // add r18, r1, r1
